/* Makefile */
BIN := obj_dir/Vtb_ofdm_rx_ctrl

.PHONY: all run clean

all: run

$(BIN): files.f $(wildcard src/*.sv sim/*.sv include/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_ofdm_rx_ctrl

run: $(BIN)
	$(BIN) | tee sim.log
	! grep -q "TEST FAIL" sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+include
src/rx_pkg.sv
src/hdr_if.sv
src/fcs_if.sv
src/signal_field_parser.sv
src/crc32_byte.sv
src/psdu_receiver.sv
src/rx_report.sv
src/ofdm_rx_ctrl.sv
sim/tb_ofdm_rx_ctrl.sv

/* include/tb_rx_tasks.svh */
`ifndef TB_RX_TASKS_SVH
`define TB_RX_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// byte drivers returning 1 ns after a rising edge
////////////////////////////////////////////////////////////////////////////

task automatic drive_byte(input rx_pkg::byte_t b);
    byte_i = b;
    byte_strobe_i = 1'b1;
    @(posedge clock);
    #1;
    byte_strobe_i = 1'b0;
endtask

task automatic pulse_start();
    pkt_start_i = 1'b1;
    @(posedge clock);
    #1;
    pkt_start_i = 1'b0;
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clock);
        #1;
    end
endtask

// optional start pulse then n bytes of frame_q from index first
task automatic send_bytes(input bit with_start, input int first, input int n);
    if (with_start) pulse_start();
    for (int i = first; i < first + n; i++) begin
        drive_byte(frame_q[i]);
    end
endtask

// bounded wait for the header or FCS strobe at the top level
task automatic wait_strobe(input string name, input bit fcs_side);
    int i;
    i = 0;
    while (!(fcs_side ? fcs_out_strobe_o : pkt_header_valid_strobe_o) && i < WAIT_LIMIT) begin
        @(posedge clock);
        #1;
        i++;
    end
    if (!(fcs_side ? fcs_out_strobe_o : pkt_header_valid_strobe_o)) begin
        $display("%s: no %s strobe within %0d cycles", name, fcs_side ? "FCS" : "header",
                 WAIT_LIMIT);
        errors++;
    end
endtask

task automatic report_mismatch(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    $display("Mismatch in %s, %s: expected %0h, actual %0h", name, field, expected, actual);
    errors++;
endtask

////////////////////////////////////////////////////////////////////////////
// frame construction
////////////////////////////////////////////////////////////////////////////

// legacy SIGNAL layout with even parity over bits 17..0
function automatic rx_pkg::sig_bits_t make_sig(input rx_pkg::rate_t rate, input rx_pkg::len_t len,
                                               input logic rsvd, input logic [5:0] tail,
                                               input logic flip_parity);
    rx_pkg::sig_bits_t s;
    s = '0;
    s[3:0] = rate;
    s[4] = rsvd;
    s[16:5] = len;
    s[17] = (^s[16:0]) ^ flip_parity;
    s[23:18] = tail;
    return s;
endfunction

// standard CRC-32 on an msb first register fed in line bit order
function automatic rx_pkg::crc_t crc32_ieee(input rx_pkg::byte_t data[$]);
    rx_pkg::crc_t c;
    rx_pkg::crc_t r;
    c = 32'hffff_ffff;
    foreach (data[k]) begin
        for (int i = 0; i < 8; i++) begin
            c = (c[31] ^ data[k][i]) ? ((c << 1) ^ 32'h04c1_1db7) : (c << 1);
        end
    end
    // result reflected back to line order
    for (int i = 0; i < 32; i++) begin
        r[i] = c[31 - i];
    end
    return ~r;
endfunction

task automatic load_sig(input rx_pkg::sig_bits_t sig);
    frame_q.delete();
    for (int i = 0; i < 3; i++) begin
        frame_q.push_back(sig[8 * i +: 8]);
    end
endtask

// len counts the whole PSDU including its 4 FCS bytes
task automatic build_frame(input rx_pkg::rate_t rate, input rx_pkg::len_t len, input bit corrupt);
    rx_pkg::byte_t payload_q[$];
    rx_pkg::crc_t  fcs_val;
    int            rnd;
    load_sig(make_sig(rate, len, 1'b0, 6'd0, 1'b0));
    for (int i = 0; i < int'(len) - 4; i++) begin
        rnd = $random(seed);
        payload_q.push_back(rnd[7:0]);
    end
    fcs_val = crc32_ieee(payload_q);
    // damage one byte after the FCS is fixed
    if (corrupt) payload_q[2] = payload_q[2] ^ 8'h10;
    foreach (payload_q[k]) begin
        frame_q.push_back(payload_q[k]);
    end
    for (int i = 0; i < 4; i++) begin
        frame_q.push_back(fcs_val[8 * i +: 8]);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////

task automatic receive_frame(input string name, input rx_pkg::rate_t rate,
                             input rx_pkg::len_t len, input bit corrupt);
    int              hdr0;
    int              fcs0;
    rx_pkg::status_t exp_status;
    hdr0 = hdr_strobes;
    fcs0 = fcs_strobes;
    exp_status = corrupt ? rx_pkg::ST_WRONG_FCS : rx_pkg::ST_OK;
    build_frame(rate, len, corrupt);
    send_bytes(1'b1, 0, 3);
    busy_expected = 1'b1;
    wait_strobe(name, 1'b0);
    if (pkt_header_valid_o !== 1'b1) report_mismatch(name, "valid", 32'h1, 32'(pkt_header_valid_o));
    if (pkt_rate_o !== rate) report_mismatch(name, "rate", 32'(rate), 32'(pkt_rate_o));
    if (pkt_len_o !== len) report_mismatch(name, "length", 32'(len), 32'(pkt_len_o));
    if (status_code_o !== rx_pkg::ST_OK) begin
        report_mismatch(name, "header status", 32'(rx_pkg::ST_OK), 32'(status_code_o));
    end
    send_bytes(1'b0, 3, int'(len));
    wait_strobe(name, 1'b1);
    busy_expected = 1'b0;
    if (fcs_ok_o !== !corrupt) report_mismatch(name, "fcs_ok", 32'(!corrupt), 32'(fcs_ok_o));
    if (status_code_o !== exp_status) begin
        report_mismatch(name, "status", 32'(exp_status), 32'(status_code_o));
    end
    if (byte_count_o !== len) report_mismatch(name, "byte count", 32'(len), 32'(byte_count_o));
    if (busy_o !== 1'b0) report_mismatch(name, "busy at FCS strobe", 32'h0, 32'(busy_o));
    idle_cycles(1);
    if (busy_o !== 1'b0) report_mismatch(name, "busy after frame", 32'h0, 32'(busy_o));
    if (hdr_strobes - hdr0 != 1) report_mismatch(name, "header strobes", 32'h1, hdr_strobes - hdr0);
    if (fcs_strobes - fcs0 != 1) report_mismatch(name, "FCS strobes", 32'h1, fcs_strobes - fcs0);
endtask

task automatic reject_bad_signal(input string name, input rx_pkg::sig_bits_t sig,
                                 input rx_pkg::status_t exp_status);
    int hdr0;
    int fcs0;
    int rnd;
    hdr0 = hdr_strobes;
    fcs0 = fcs_strobes;
    load_sig(sig);
    send_bytes(1'b1, 0, 3);
    wait_strobe(name, 1'b0);
    if (pkt_header_valid_o !== 1'b0) report_mismatch(name, "valid", 32'h0, 32'(pkt_header_valid_o));
    if (status_code_o !== exp_status) begin
        report_mismatch(name, "status", 32'(exp_status), 32'(status_code_o));
    end
    if (pkt_rate_o !== sig[3:0]) report_mismatch(name, "rate", 32'(sig[3:0]), 32'(pkt_rate_o));
    if (pkt_len_o !== sig[16:5]) report_mismatch(name, "length", 32'(sig[16:5]), 32'(pkt_len_o));
    // enough trailing bytes to cover the signalled length, yet no data phase may open
    for (int i = 0; i < 4; i++) begin
        rnd = $random(seed);
        drive_byte(rnd[7:0]);
    end
    idle_cycles(4);
    if (busy_o !== 1'b0) report_mismatch(name, "busy", 32'h0, 32'(busy_o));
    if (hdr_strobes - hdr0 != 1) report_mismatch(name, "header strobes", 32'h1, hdr_strobes - hdr0);
    if (fcs_strobes != fcs0) report_mismatch(name, "FCS strobes", 32'h0, fcs_strobes - fcs0);
endtask

task automatic abort_and_restart(input string name);
    int fcs0;
    fcs0 = fcs_strobes;
    // rate 1011 is a plain 6 Mbit/s frame here
    build_frame(4'b1011, 12'd12, 1'b0);
    send_bytes(1'b1, 0, 3);
    wait_strobe(name, 1'b0);
    if (pkt_header_valid_o !== 1'b1) report_mismatch(name, "valid", 32'h1, 32'(pkt_header_valid_o));
    if (pkt_rate_o !== 4'b1011) report_mismatch(name, "rate", 32'hb, 32'(pkt_rate_o));
    send_bytes(1'b0, 3, 5);
    pulse_start();
    // remaining PSDU bytes would complete the old frame without the abort
    send_bytes(1'b0, 8, 7);
    idle_cycles(3);
    if (fcs_strobes != fcs0) report_mismatch(name, "aborted FCS strobes", 32'h0, fcs_strobes - fcs0);
    receive_frame(name, 4'b1001, 12'd24, 1'b0);
    if (fcs_strobes - fcs0 != 1) report_mismatch(name, "FCS strobes", 32'h1, fcs_strobes - fcs0);
endtask

`endif

/* sim/tb_ofdm_rx_ctrl.sv */
`timescale 1ns/1ps

module tb_ofdm_rx_ctrl;

    localparam int WAIT_LIMIT = 16;
    // SIGNAL bytes plus PSDU or trailing bytes summed over all tests
    localparam int FRAME_BYTES = 2 * (3 + 20) + 5 * (3 + 4) + (3 + 12) + (3 + 24);
    localparam int WATCHDOG_CYCLES = FRAME_BYTES * 4 + 200;

    logic              clock = 1'b0;
    logic              reset;
    logic              pkt_start_i;
    rx_pkg::byte_t     byte_i;
    logic              byte_strobe_i;
    logic              busy_o;
    logic              pkt_header_valid_strobe_o;
    logic              pkt_header_valid_o;
    rx_pkg::rate_t     pkt_rate_o;
    rx_pkg::len_t      pkt_len_o;
    rx_pkg::status_t   status_code_o;
    rx_pkg::len_t      byte_count_o;
    logic              fcs_out_strobe_o;
    logic              fcs_ok_o;

    int                errors = 0;
    int                seed = 32'hb84b5472;
    int                hdr_strobes = 0;
    int                fcs_strobes = 0;
    bit                busy_expected;
    // bytes of the frame under test with SIGNAL first
    rx_pkg::byte_t     frame_q[$];

    ofdm_rx_ctrl UUT (
        .clock                     (clock),
        .reset                     (reset),
        .pkt_start_i               (pkt_start_i),
        .byte_i                    (byte_i),
        .byte_strobe_i             (byte_strobe_i),
        .busy_o                    (busy_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .status_code_o             (status_code_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o)
    );

    always #50 clock = ~clock;

    `include "tb_rx_tasks.svh"

    // strobe counts and busy watch on the falling edge
    always @(negedge clock) begin
        if (pkt_header_valid_strobe_o) hdr_strobes++;
        if (fcs_out_strobe_o) fcs_strobes++;
        if (busy_expected && busy_o !== 1'b1) begin
            $display("busy_o dropped in the middle of a frame at %0t", $time);
            errors++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("run timed out after %0d cycles with %0d errors", WATCHDOG_CYCLES, errors);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        pkt_start_i = 1'b0;
        byte_i = '0;
        byte_strobe_i = 1'b0;
        busy_expected = 1'b0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        // all flags low and status clear out of reset
        if ({busy_o, pkt_header_valid_strobe_o, pkt_header_valid_o,
             fcs_out_strobe_o, fcs_ok_o} !== 5'b0) begin
            report_mismatch("reset", "flags", 32'h0, 32'({busy_o, pkt_header_valid_strobe_o,
                            pkt_header_valid_o, fcs_out_strobe_o, fcs_ok_o}));
        end
        if (status_code_o !== rx_pkg::ST_OK) begin
            report_mismatch("reset", "status", 32'(rx_pkg::ST_OK), 32'(status_code_o));
        end

        receive_frame("good_frame", 4'b1101, 12'd20, 1'b0);
        receive_frame("bad_fcs", 4'b1111, 12'd20, 1'b1);
        reject_bad_signal("bad_parity", make_sig(4'b1101, 12'd4, 1'b0, 6'd0, 1'b1),
                          rx_pkg::ST_PARITY_FAIL);
        reject_bad_signal("reserved_set", make_sig(4'b1101, 12'd3, 1'b1, 6'd0, 1'b0),
                          rx_pkg::ST_WRONG_RSVD);
        reject_bad_signal("nonzero_tail", make_sig(4'b1111, 12'd4, 1'b0, 6'h05, 1'b0),
                          rx_pkg::ST_WRONG_TAIL);
        reject_bad_signal("rate_0101", make_sig(4'b0101, 12'd2, 1'b0, 6'd0, 1'b0),
                          rx_pkg::ST_UNSUPPORTED_RATE);
        // parity outranks the tail check
        reject_bad_signal("parity_and_tail", make_sig(4'b1000, 12'd1, 1'b0, 6'h20, 1'b1),
                          rx_pkg::ST_PARITY_FAIL);
        abort_and_restart("abort_restart");
        idle_cycles(2);

        $display("finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* src/crc32_byte.sv */
`timescale 1ns/1ps

module crc32_byte (
    input  logic          clock,
    input  logic          reset,
    input  logic          clear_i,
    input  rx_pkg::byte_t byte_i,
    input  logic          strobe_i,
    output rx_pkg::crc_t  crc_o
);

    // IEEE 802.3 polynomial, reflected
    localparam rx_pkg::crc_t CRC_POLY = 32'hedb8_8320;

    rx_pkg::crc_t crc_q;

    // fold one byte in, lsb first
    function automatic rx_pkg::crc_t crc_fold(
        input rx_pkg::crc_t  crc,
        input rx_pkg::byte_t data
    );
        rx_pkg::crc_t c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            crc_q <= '1;
        end else if (strobe_i) begin
            crc_q <= crc_fold(crc_q, byte_i);
        end
    end

    // raw register, no final inversion
    assign crc_o = crc_q;

endmodule

/* src/fcs_if.sv */
`timescale 1ns/1ps

// data phase progress and FCS verdict
interface fcs_if;

    logic           receiving;
    rx_pkg::len_t   byte_count;
    logic           fcs_strobe;
    logic           fcs_ok;

    modport data (
        output receiving, byte_count, fcs_strobe, fcs_ok
    );

    modport report (
        input receiving, byte_count, fcs_strobe, fcs_ok
    );

endinterface

/* src/hdr_if.sv */
`timescale 1ns/1ps

// checked SIGNAL header, parser to data and report stages
interface hdr_if;

    logic              hdr_strobe;
    logic              hdr_ok;
    rx_pkg::rate_t     rate;
    rx_pkg::len_t      len;
    rx_pkg::status_t   hdr_status;
    // high from start pulse through the header strobe
    logic              parsing;

    modport parser (
        output hdr_strobe, hdr_ok, rate, len, hdr_status, parsing
    );

    modport data (
        input hdr_strobe, hdr_ok, len
    );

    modport report (
        input hdr_strobe, hdr_ok, rate, len, hdr_status, parsing
    );

endinterface

/* src/ofdm_rx_ctrl.sv */
`timescale 1ns/1ps

module ofdm_rx_ctrl (
    input  logic            clock,
    input  logic            reset,
    input  logic            pkt_start_i,
    input  rx_pkg::byte_t   byte_i,
    input  logic            byte_strobe_i,
    output logic            busy_o,
    output logic            pkt_header_valid_strobe_o,
    output logic            pkt_header_valid_o,
    output rx_pkg::rate_t   pkt_rate_o,
    output rx_pkg::len_t    pkt_len_o,
    output rx_pkg::status_t status_code_o,
    output rx_pkg::len_t    byte_count_o,
    output logic            fcs_out_strobe_o,
    output logic            fcs_ok_o
);

    hdr_if hdr ();
    fcs_if fcs ();

    ////////////////////////////////////////////////////////////////////////////
    // decode, execute and result stages
    ////////////////////////////////////////////////////////////////////////////

    signal_field_parser u_parser (
        .clock         (clock),
        .reset         (reset),
        .pkt_start_i   (pkt_start_i),
        .byte_i        (byte_i),
        .byte_strobe_i (byte_strobe_i),
        .hdr           (hdr.parser)
    );

    psdu_receiver u_psdu (
        .clock         (clock),
        .reset         (reset),
        .pkt_start_i   (pkt_start_i),
        .byte_i        (byte_i),
        .byte_strobe_i (byte_strobe_i),
        .hdr           (hdr.data),
        .fcs           (fcs.data)
    );

    rx_report u_report (
        .clock                     (clock),
        .reset                     (reset),
        .hdr                       (hdr.report),
        .fcs                       (fcs.report),
        .busy_o                    (busy_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .status_code_o             (status_code_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o)
    );

endmodule

/* src/psdu_receiver.sv */
`timescale 1ns/1ps

module psdu_receiver (
    input  logic          clock,
    input  logic          reset,
    input  logic          pkt_start_i,
    input  rx_pkg::byte_t byte_i,
    input  logic          byte_strobe_i,
    hdr_if.data           hdr,
    fcs_if.data           fcs
);

    rx_pkg::psdu_state_t state;
    rx_pkg::len_t        len_q;
    rx_pkg::len_t        count_q;
    rx_pkg::len_t        count_next;
    rx_pkg::crc_t        crc;
    logic                start_data;
    logic                crc_strobe;

    assign start_data = (state == rx_pkg::DS_IDLE) && hdr.hdr_strobe && hdr.hdr_ok
                        && !pkt_start_i;
    assign crc_strobe = (state == rx_pkg::DS_DATA) && byte_strobe_i && !pkt_start_i;
    assign count_next = count_q + 12'd1;

    assign fcs.receiving  = (state != rx_pkg::DS_IDLE);
    assign fcs.byte_count = count_q;

    crc32_byte u_crc (
        .clock    (clock),
        .reset    (reset),
        .clear_i  (start_data),
        .byte_i   (byte_i),
        .strobe_i (crc_strobe),
        .crc_o    (crc)
    );

    always_ff @(posedge clock) begin
        if (start_data) begin
            len_q <= hdr.len;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= rx_pkg::DS_IDLE;
            count_q        <= '0;
            fcs.fcs_strobe <= 1'b0;
            fcs.fcs_ok     <= 1'b0;
        end else begin
            fcs.fcs_strobe <= 1'b0;
            if (pkt_start_i) begin
                // abort, no verdict for this frame
                state <= rx_pkg::DS_IDLE;
            end else begin
                case (state)
                    rx_pkg::DS_IDLE: begin
                        if (start_data) begin
                            count_q <= '0;
                            // empty PSDU has no FCS to check
                            state <= (hdr.len == '0) ? rx_pkg::DS_FINISH : rx_pkg::DS_DATA;
                        end
                    end
                    rx_pkg::DS_DATA: begin
                        if (byte_strobe_i) begin
                            count_q <= count_next;
                            if (count_next == len_q) begin
                                state <= rx_pkg::DS_FINISH;
                            end
                        end
                    end
                    rx_pkg::DS_FINISH: begin
                        fcs.fcs_strobe <= 1'b1;
                        fcs.fcs_ok     <= (crc == rx_pkg::FCS_RESIDUE);
                        state          <= rx_pkg::DS_IDLE;
                    end
                    default: state <= rx_pkg::DS_IDLE;
                endcase
            end
        end
    end

    a_fcs_after_rx : assert property (
        @(posedge clock) disable iff (reset)
        fcs.fcs_strobe |-> $past(fcs.receiving)
    );

endmodule

/* src/rx_pkg.sv */
package rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////////////////////

    // one decoded byte from the front end
    typedef logic [7:0] byte_t;

    // legacy rate code, bit 3 set for supported OFDM rates
    typedef logic [3:0] rate_t;

    // PSDU length in bytes as carried in SIGNAL
    typedef logic [11:0] len_t;

    // raw SIGNAL field, first byte in bits 7..0
    typedef logic [23:0] sig_bits_t;

    // CRC-32 register
    typedef logic [31:0] crc_t;

    ////////////////////////////////////////////////////////////////////////////
    // status codes and FSM states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_OK               = 3'd0,
        ST_PARITY_FAIL      = 3'd1,
        ST_WRONG_RSVD       = 3'd2,
        ST_WRONG_TAIL       = 3'd3,
        ST_UNSUPPORTED_RATE = 3'd4,
        ST_WRONG_FCS        = 3'd5
    } status_t;

    typedef enum logic [1:0] {PS_IDLE, PS_COLLECT, PS_CHECK} parser_state_t;

    typedef enum logic [1:0] {DS_IDLE, DS_DATA, DS_FINISH} psdu_state_t;

    // raw register after payload plus complemented FCS, reflected form
    localparam crc_t FCS_RESIDUE = 32'hdebb_20e3;

    localparam int unsigned SIG_BYTES = 3;

endpackage

/* src/rx_report.sv */
`timescale 1ns/1ps

module rx_report (
    input  logic            clock,
    input  logic            reset,
    hdr_if.report           hdr,
    fcs_if.report           fcs,
    output logic            busy_o,
    output logic            pkt_header_valid_strobe_o,
    output logic            pkt_header_valid_o,
    output rx_pkg::rate_t   pkt_rate_o,
    output rx_pkg::len_t    pkt_len_o,
    output rx_pkg::status_t status_code_o,
    output rx_pkg::len_t    byte_count_o,
    output logic            fcs_out_strobe_o,
    output logic            fcs_ok_o
);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_o                    <= 1'b0;
            pkt_header_valid_strobe_o <= 1'b0;
            pkt_header_valid_o        <= 1'b0;
            pkt_rate_o                <= '0;
            pkt_len_o                 <= '0;
            status_code_o             <= rx_pkg::ST_OK;
            byte_count_o              <= '0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_ok_o                  <= 1'b0;
        end else begin
            busy_o                    <= hdr.parsing | fcs.receiving;
            pkt_header_valid_strobe_o <= hdr.hdr_strobe;
            fcs_out_strobe_o          <= fcs.fcs_strobe;
            byte_count_o              <= fcs.byte_count;

            // header fields held until the next header
            if (hdr.hdr_strobe) begin
                pkt_header_valid_o <= hdr.hdr_ok;
                pkt_rate_o         <= hdr.rate;
                pkt_len_o          <= hdr.len;
                status_code_o      <= hdr.hdr_status;
            end

            // FCS verdict overrides the header status
            if (fcs.fcs_strobe) begin
                fcs_ok_o      <= fcs.fcs_ok;
                status_code_o <= fcs.fcs_ok ? rx_pkg::ST_OK : rx_pkg::ST_WRONG_FCS;
            end
        end
    end

    a_strobes_apart : assert property (
        @(posedge clock) disable iff (reset)
        !(fcs_out_strobe_o && pkt_header_valid_strobe_o)
    );

endmodule

/* src/signal_field_parser.sv */
`timescale 1ns/1ps

module signal_field_parser (
    input  logic          clock,
    input  logic          reset,
    input  logic          pkt_start_i,
    input  rx_pkg::byte_t byte_i,
    input  logic          byte_strobe_i,
    hdr_if.parser         hdr
);

    rx_pkg::parser_state_t state;
    rx_pkg::sig_bits_t     sig_q;
    rx_pkg::status_t       chk_status;
    logic [1:0]            byte_cnt;
    logic                  last_sig_byte;

    assign last_sig_byte = (byte_cnt == 2'(rx_pkg::SIG_BYTES - 1));

    // field checks, first failure wins
    always_comb begin
        if (^sig_q[17:0]) begin
            chk_status = rx_pkg::ST_PARITY_FAIL;
        end else if (sig_q[4]) begin
            chk_status = rx_pkg::ST_WRONG_RSVD;
        end else if (|sig_q[23:18]) begin
            chk_status = rx_pkg::ST_WRONG_TAIL;
        end else if (!sig_q[3]) begin
            chk_status = rx_pkg::ST_UNSUPPORTED_RATE;
        end else begin
            chk_status = rx_pkg::ST_OK;
        end
    end

    // SIGNAL bytes arrive lsb byte first
    always_ff @(posedge clock) begin
        if (state == rx_pkg::PS_COLLECT && byte_strobe_i && !pkt_start_i) begin
            sig_q <= {byte_i, sig_q[23:8]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= rx_pkg::PS_IDLE;
            byte_cnt       <= 2'd0;
            hdr.hdr_strobe <= 1'b0;
            hdr.parsing    <= 1'b0;
        end else begin
            hdr.hdr_strobe <= 1'b0;
            if (hdr.hdr_strobe) begin
                hdr.parsing <= 1'b0;
            end
            if (pkt_start_i) begin
                // restart collection from any state
                state       <= rx_pkg::PS_COLLECT;
                byte_cnt    <= 2'd0;
                hdr.parsing <= 1'b1;
            end else begin
                case (state)
                    rx_pkg::PS_COLLECT: begin
                        if (byte_strobe_i) begin
                            byte_cnt <= byte_cnt + 2'd1;
                            if (last_sig_byte) begin
                                state <= rx_pkg::PS_CHECK;
                            end
                        end
                    end
                    rx_pkg::PS_CHECK: begin
                        hdr.hdr_strobe <= 1'b1;
                        state          <= rx_pkg::PS_IDLE;
                    end
                    default: state <= rx_pkg::PS_IDLE;
                endcase
            end
        end
    end

    // header fields, valid with hdr_strobe
    always_ff @(posedge clock) begin
        if (state == rx_pkg::PS_CHECK) begin
            hdr.hdr_ok     <= (chk_status == rx_pkg::ST_OK);
            hdr.hdr_status <= chk_status;
            hdr.rate       <= sig_q[3:0];
            hdr.len        <= sig_q[16:5];
        end
    end

    a_single_hdr_strobe : assert property (
        @(posedge clock) disable iff (reset)
        hdr.hdr_strobe |=> !hdr.hdr_strobe
    );

endmodule
